// File: logic/pipe_consts.svh
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// Datapath and address width.
`define XLEN 32

// Architectural register index.
`define REG_IDX_W 5

// Data memory geometry, in 32-bit words.
`define DMEM_WORDS 256
`define DMEM_AW 8    // log2 of DMEM_WORDS.

`endif

// File: logic/pipe_pkg.sv
`default_nettype none

`include "pipe_consts.svh"

package pipe_pkg;

    typedef logic [`XLEN-1:0]      xword_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // Access size, same coding as funct3 of loads and stores.
    typedef enum logic [2:0] {
        DM_B  = 3'b000,
        DM_H  = 3'b001,
        DM_W  = 3'b010,
        DM_BU = 3'b100,
        DM_HU = 3'b101
    } dm_ctrl_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'b00,
        WB_MEM = 2'b01,
        WB_PC4 = 2'b10    // Link value for jal/jalr.
    } wb_src_e;

    // EX/MEM bundle; all zeros is a NOP.
    typedef struct packed {
        xword_t   pc_plus_4;
        xword_t   alu_result;    // Also the branch target when pc_src is set.
        xword_t   rs2_data;      // Store data.
        reg_idx_t rd;
        logic     pc_src;
        logic     rf_wr;
        logic     dm_wr;
        dm_ctrl_e dm_ctrl;
        wb_src_e  wb_src;
        logic     ebreak;
    } ex_mem_t;

    // MEM/WB bundle, the register-file write and the halt.
    typedef struct packed {
        logic     rf_wr;
        reg_idx_t rd;
        xword_t   wb_data;
        logic     ebreak;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: logic/ex_mem_reg.sv
`default_nettype none

`include "pipe_consts.svh"

module ex_mem_reg (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              flush,
    input  pipe_pkg::ex_mem_t d,
    output pipe_pkg::ex_mem_t q
);

    import pipe_pkg::*;

    // No register write, no store, no redirect, no halt.
    localparam ex_mem_t NOP = '{
        pc_plus_4:  {`XLEN{1'b0}},
        alu_result: {`XLEN{1'b0}},
        rs2_data:   {`XLEN{1'b0}},
        rd:         {`REG_IDX_W{1'b0}},
        pc_src:     1'b0,
        rf_wr:      1'b0,
        dm_wr:      1'b0,
        dm_ctrl:    DM_B,
        wb_src:     WB_ALU,
        ebreak:     1'b0
    };

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= NOP;
        end else if (flush) begin
            // Flush wins over stall.
            q <= NOP;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// File: logic/data_mem.sv
`default_nettype none

`include "pipe_consts.svh"

module data_mem (
    input  logic                clk,
    input  logic [`DMEM_AW-1:0] addr,
    input  pipe_pkg::xword_t    wdata,
    input  logic [3:0]          be,
    input  logic                we,
    output pipe_pkg::xword_t    rdata
);

    import pipe_pkg::*;

    xword_t mem [`DMEM_WORDS];

    // Byte-lane writes on the clock edge.
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // Asynchronous read of the whole word.
    assign rdata = mem[addr];

endmodule

`default_nettype wire

// File: logic/mem_stage.sv
`default_nettype none

`include "pipe_consts.svh"

module mem_stage (
    input  logic                stall,
    input  pipe_pkg::ex_mem_t   mem_in,
    output logic [`DMEM_AW-1:0] dm_addr,
    output pipe_pkg::xword_t    dm_wdata,
    output logic [3:0]          dm_be,
    output logic                dm_we,
    input  pipe_pkg::xword_t    dm_rdata,
    output pipe_pkg::mem_wb_t   wb_next
);

    import pipe_pkg::*;

    logic [1:0]  byte_off;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    xword_t      ld_data;
    xword_t      wb_data;

    assign byte_off = mem_in.alu_result[1:0];
    assign dm_addr  = mem_in.alu_result[`DMEM_AW+1:2];   // Word index.
    assign dm_we    = mem_in.dm_wr & ~stall;             // No store while held.

    // Store data is replicated, the enables pick the lanes.
    always_comb begin
        case (mem_in.dm_ctrl)
            DM_B, DM_BU: begin
                dm_wdata = {4{mem_in.rs2_data[7:0]}};
                dm_be    = 4'b0001 << byte_off;
            end
            DM_H, DM_HU: begin
                dm_wdata = {2{mem_in.rs2_data[15:0]}};
                dm_be    = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                dm_wdata = mem_in.rs2_data;
                dm_be    = 4'b1111;
            end
        endcase
    end

    assign ld_byte = dm_rdata[{byte_off, 3'b000} +: 8];
    assign ld_half = dm_rdata[{byte_off[1], 4'b0000} +: 16];

    // Load extension.
    always_comb begin
        case (mem_in.dm_ctrl)
            DM_B:    ld_data = {{(`XLEN-8){ld_byte[7]}}, ld_byte};
            DM_BU:   ld_data = {{(`XLEN-8){1'b0}}, ld_byte};
            DM_H:    ld_data = {{(`XLEN-16){ld_half[15]}}, ld_half};
            DM_HU:   ld_data = {{(`XLEN-16){1'b0}}, ld_half};
            default: ld_data = dm_rdata;
        endcase
    end

    always_comb begin
        case (mem_in.wb_src)
            WB_MEM:  wb_data = ld_data;
            WB_PC4:  wb_data = mem_in.pc_plus_4;
            default: wb_data = mem_in.alu_result;
        endcase
    end

    // A stalled cycle leaves a bubble behind.
    always_comb begin
        wb_next.rf_wr   = mem_in.rf_wr & ~stall;
        wb_next.rd      = mem_in.rd;
        wb_next.wb_data = wb_data;
        wb_next.ebreak  = mem_in.ebreak & ~stall;
    end

endmodule

`default_nettype wire

// File: logic/mem_wb_reg.sv
`default_nettype none

module mem_wb_reg (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::mem_wb_t d,
    output pipe_pkg::mem_wb_t q
);

    import pipe_pkg::*;

    localparam mem_wb_t BUBBLE = '{
        rf_wr:   1'b0,
        rd:      '0,
        wb_data: '0,
        ebreak:  1'b0
    };

    // Stall bubbles come in through d.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= BUBBLE;
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// File: logic/mem_wb_top.sv
`default_nettype none

`include "pipe_consts.svh"

module mem_wb_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              flush,
    input  pipe_pkg::ex_mem_t ex_bundle,
    output pipe_pkg::mem_wb_t wb,
    output logic              pc_src,
    output pipe_pkg::xword_t  branch_target
);

    import pipe_pkg::*;

    ex_mem_t             mem_in;
    mem_wb_t             wb_next;
    logic [`DMEM_AW-1:0] dm_addr;
    xword_t              dm_wdata;
    xword_t              dm_rdata;
    logic [3:0]          dm_be;
    logic                dm_we;

    ex_mem_reg i_ex_mem_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .flush (flush),
        .d     (ex_bundle),
        .q     (mem_in)
    );

    mem_stage i_mem_stage (
        .stall    (stall),
        .mem_in   (mem_in),
        .dm_addr  (dm_addr),
        .dm_wdata (dm_wdata),
        .dm_be    (dm_be),
        .dm_we    (dm_we),
        .dm_rdata (dm_rdata),
        .wb_next  (wb_next)
    );

    data_mem i_data_mem (
        .clk   (clk),
        .addr  (dm_addr),
        .wdata (dm_wdata),
        .be    (dm_be),
        .we    (dm_we),
        .rdata (dm_rdata)
    );

    mem_wb_reg i_mem_wb_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (wb_next),
        .q     (wb)
    );

    // Redirect leaves from EX/MEM, one cycle after EX.
    assign pc_src        = mem_in.pc_src;
    assign branch_target = mem_in.alu_result;

endmodule

`default_nettype wire

// File: dv/mem_wb_props.sv
`default_nettype none

module mem_wb_props (
    input logic              clk,
    input logic              rst_n,
    input logic              stall,
    input logic              flush,
    input logic              dm_we,
    input logic              pc_src,
    input pipe_pkg::mem_wb_t wb
);

    import pipe_pkg::*;

    int failures = 0;   // Failed assertions so far.

    // Registers are cleared while reset is held.
    property reset_clears_outputs;
        @(posedge clk) !rst_n |=> (!wb.rf_wr && !pc_src);
    endproperty

    // A flushed bundle never reaches the memory port.
    property flush_blocks_store;
        @(posedge clk) disable iff (!rst_n)
            flush |=> !dm_we;
    endproperty

    property stall_gives_bubble;
        @(posedge clk) disable iff (!rst_n)
            stall |=> (!wb.rf_wr && !wb.ebreak);
    endproperty

    reset_check: assert property (reset_clears_outputs)
        else begin
            failures++;
            $error("Register write or redirect active during reset.");
        end

    flush_check: assert property (flush_blocks_store)
        else begin
            failures++;
            $error("Memory write in the cycle after a flush.");
        end

    stall_check: assert property (stall_gives_bubble)
        else begin
            failures++;
            $error("Write-back or halt in the cycle after a stall.");
        end

endmodule

bind mem_wb_top mem_wb_props i_mem_wb_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .stall  (stall),
    .flush  (flush),
    .dm_we  (dm_we),
    .pc_src (pc_src),
    .wb     (wb)
);

`default_nettype wire

// File: dv/tb_mem_wb.sv
`default_nettype none

`include "pipe_consts.svh"

module tb_mem_wb;

    import pipe_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int N_ALU        = 24;
    localparam int N_WORD       = 8;
    localparam int N_NARROW     = 8;
    localparam int N_LOAD       = 20;
    localparam int N_LINK       = 6;
    localparam int STALL_LEN    = 4;
    localparam int N_TESTS      = 7;
    // Stimulus cycles plus a drain allowance of 10 per test.
    localparam int RUN_CYCLES   = RESET_CYCLES + N_ALU + N_WORD + N_NARROW + N_LOAD
                                + N_LINK + 4 + (2 * STALL_LEN + 4) + 2 + N_TESTS * 10;
    localparam int MAX_CYCLES   = RUN_CYCLES + 200;
    localparam ex_mem_t NOP     = '0;

    logic    clk;
    logic    rst_n;
    logic    stall;
    logic    flush;
    ex_mem_t ex_bundle;
    mem_wb_t wb;
    logic    pc_src;
    xword_t  branch_target;

    logic [7:0] ref_mem [4*`DMEM_WORDS];   // Byte-wide reference memory.
    ex_mem_t    model_q = '0;              // What EX/MEM should hold.
    mem_wb_t    exp_q [$];
    dm_ctrl_e   load_sizes [5] = '{DM_B, DM_H, DM_W, DM_BU, DM_HU};
    int         words [$];
    int         cycles    = 0;
    int         checks    = 0;
    int         errors    = 0;
    int         err_mark  = 0;
    int         prop_mark = 0;
    int         tests     = 0;

    mem_wb_top i_mem_wb_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .flush         (flush),
        .ex_bundle     (ex_bundle),
        .wb            (wb),
        .pc_src        (pc_src),
        .branch_target (branch_target)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    function automatic xword_t load_ref(xword_t addr, dm_ctrl_e ctrl);
        int          base;
        int          half;
        logic [7:0]  b;
        logic [15:0] h;
        base = int'(addr[`DMEM_AW+1:2]) * 4;
        half = addr[1] ? 2 : 0;
        b    = ref_mem[base + int'(addr[1:0])];
        h    = {ref_mem[base + half + 1], ref_mem[base + half]};
        case (ctrl)
            DM_B:    return {{(`XLEN-8){b[7]}}, b};
            DM_BU:   return {{(`XLEN-8){1'b0}}, b};
            DM_H:    return {{(`XLEN-16){h[15]}}, h};
            DM_HU:   return {{(`XLEN-16){1'b0}}, h};
            default: return {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
        endcase
    endfunction

    function automatic void store_ref(xword_t addr, dm_ctrl_e ctrl, xword_t data);
        int base;
        int half;
        base = int'(addr[`DMEM_AW+1:2]) * 4;
        half = addr[1] ? 2 : 0;
        case (ctrl)
            DM_B, DM_BU: ref_mem[base + int'(addr[1:0])] = data[7:0];
            DM_H, DM_HU: begin
                ref_mem[base + half]     = data[7:0];
                ref_mem[base + half + 1] = data[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[base + i] = data[8*i +: 8];
                end
            end
        endcase
    endfunction

    function automatic mem_wb_t expected_wb(ex_mem_t b);
        mem_wb_t e;
        e.rf_wr  = b.rf_wr;
        e.rd     = b.rd;
        e.ebreak = b.ebreak;
        case (b.wb_src)
            WB_MEM:  e.wb_data = load_ref(b.alu_result, b.dm_ctrl);
            WB_PC4:  e.wb_data = b.pc_plus_4;
            default: e.wb_data = b.alu_result;
        endcase
        return e;
    endfunction

    // Reference pipeline; the load sees memory before this edge's store.
    always @(posedge clk) begin
        if (!rst_n) begin
            model_q = NOP;
        end else begin
            if (!stall && (model_q.rf_wr || model_q.ebreak)) begin
                exp_q.push_back(expected_wb(model_q));
            end
            if (!stall && model_q.dm_wr) begin
                store_ref(model_q.alu_result, model_q.dm_ctrl, model_q.rs2_data);
            end
            if (flush) begin
                model_q = NOP;
            end else if (!stall) begin
                model_q = ex_bundle;
            end
        end
    end

    function automatic xword_t addr_of(int idx, int off);
        return xword_t'(idx * 4 + off);
    endfunction

    function automatic ex_mem_t alu_bundle(int rd, xword_t val);
        ex_mem_t b;
        b            = NOP;
        b.rf_wr      = 1'b1;
        b.rd         = reg_idx_t'(rd);
        b.alu_result = val;
        return b;
    endfunction

    function automatic ex_mem_t store_bundle(xword_t addr, xword_t data, dm_ctrl_e size);
        ex_mem_t b;
        b            = NOP;
        b.dm_wr      = 1'b1;
        b.alu_result = addr;
        b.rs2_data   = data;
        b.dm_ctrl    = size;
        return b;
    endfunction

    function automatic ex_mem_t load_bundle(int rd, xword_t addr, dm_ctrl_e size);
        ex_mem_t b;
        b         = alu_bundle(rd, addr);
        b.wb_src  = WB_MEM;
        b.dm_ctrl = size;
        return b;
    endfunction

    task automatic check_outputs();
        mem_wb_t exp;
        checks++;
        if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            assert (wb === exp) else begin
                errors++;
                $display("[ERROR] %0t: wb rf_wr=%b rd=%0d data=%h ebreak=%b, expected %b %0d %h %b",
                         $time, wb.rf_wr, wb.rd, wb.wb_data, wb.ebreak,
                         exp.rf_wr, exp.rd, exp.wb_data, exp.ebreak);
            end
        end else begin
            assert (!wb.rf_wr && !wb.ebreak) else begin
                errors++;
                $display("[ERROR] %0t: write-back rd=%0d with nothing due", $time, wb.rd);
            end
        end
        assert (pc_src === model_q.pc_src) else begin
            errors++;
            $display("[ERROR] %0t: pc_src=%b, expected %b", $time, pc_src, model_q.pc_src);
        end
        if (model_q.pc_src) begin
            assert (branch_target === model_q.alu_result) else begin
                errors++;
                $display("[ERROR] %0t: branch_target=%h, expected %h",
                         $time, branch_target, model_q.alu_result);
            end
        end
    endtask

    // Drive on the falling edge, check one cycle later.
    task automatic step(ex_mem_t b, logic st, logic fl);
        ex_bundle = b;
        stall     = st;
        flush     = fl;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic finish_test(string name);
        // At least one idle cycle, so a squashed bundle would show at wb.
        do begin
            step(NOP, 1'b0, 1'b0);
        end while (model_q.rf_wr || model_q.ebreak || model_q.dm_wr || model_q.pc_src
                   || exp_q.size() > 0);
        errors   += i_mem_wb_top.i_mem_wb_props.failures - prop_mark;
        prop_mark = i_mem_wb_top.i_mem_wb_props.failures;
        tests++;
        $display("%0t: %s finished with %0d errors", $time, name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        ex_mem_t  b;
        dm_ctrl_e size;
        int       idx;
        int       off;
        clk              = 1'b0;
        rst_n            = 1'b0;
        stall            = 1'b0;
        flush            = 1'b0;
        ex_bundle        = alu_bundle(1, 32'h0);
        ex_bundle.pc_src = 1'b1;   // Live bundle, held off by reset.
        void'($urandom(32'h625e_7576));
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        repeat (N_ALU) step(alu_bundle($urandom_range(0, 31), $urandom), 1'b0, 1'b0);
        finish_test("alu_writeback");

        repeat (N_WORD) begin
            idx = $urandom_range(0, `DMEM_WORDS - 1);
            words.push_back(idx);
            step(store_bundle(addr_of(idx, 0), $urandom, DM_W), 1'b0, 1'b0);
        end
        repeat (N_NARROW) begin
            idx = words[$urandom_range(0, words.size() - 1)];
            if ($urandom_range(0, 1)) begin
                b = store_bundle(addr_of(idx, $urandom_range(0, 3)), $urandom, DM_B);
            end else begin
                b = store_bundle(addr_of(idx, 2 * $urandom_range(0, 1)), $urandom, DM_H);
            end
            step(b, 1'b0, 1'b0);
        end
        for (int i = 0; i < N_LOAD; i++) begin
            idx  = words[$urandom_range(0, words.size() - 1)];
            size = load_sizes[i % 5];   // Every size in turn.
            case (size)
                DM_B, DM_BU: off = $urandom_range(0, 3);
                DM_H, DM_HU: off = 2 * $urandom_range(0, 1);
                default:     off = 0;
            endcase
            step(load_bundle($urandom_range(0, 31), addr_of(idx, off), size), 1'b0, 1'b0);
        end
        finish_test("store_load");

        for (int i = 0; i < N_LINK; i++) begin
            b           = alu_bundle($urandom_range(0, 31), $urandom & 32'hffff_fffc);
            b.wb_src    = WB_PC4;
            b.pc_plus_4 = $urandom & 32'hffff_fffc;
            b.pc_src    = i[0];
            step(b, 1'b0, 1'b0);
        end
        finish_test("link_value");

        idx = $urandom_range(0, `DMEM_WORDS - 1);
        step(store_bundle(addr_of(idx, 0), $urandom, DM_W), 1'b0, 1'b0);
        step(store_bundle(addr_of(idx, 0), $urandom, DM_W), 1'b0, 1'b1);
        step(alu_bundle($urandom_range(1, 31), $urandom), 1'b0, 1'b1);
        step(load_bundle($urandom_range(0, 31), addr_of(idx, 0), DM_W), 1'b0, 1'b0);
        finish_test("flush");

        idx = $urandom_range(0, `DMEM_WORDS - 1);
        off = $urandom_range(0, 3);
        step(store_bundle(addr_of(idx, 0), $urandom, DM_W), 1'b0, 1'b0);
        step(store_bundle(addr_of(idx, off), $urandom, DM_B), 1'b0, 1'b0);
        b = load_bundle($urandom_range(0, 31), addr_of(idx, off), DM_BU);
        repeat (STALL_LEN) step(b, 1'b1, 1'b0);   // Load waits at the input.
        step(b, 1'b0, 1'b0);
        step(alu_bundle($urandom_range(0, 31), $urandom), 1'b0, 1'b0);
        repeat (STALL_LEN) step(NOP, 1'b1, 1'b0);
        finish_test("stall");

        b            = NOP;
        b.ebreak     = 1'b1;
        b.alu_result = $urandom;
        step(b, 1'b0, 1'b0);
        finish_test("halt");
        step(b, 1'b0, 1'b1);
        finish_test("flushed_halt");

        $display("%0d tests run, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+logic
logic/pipe_pkg.sv
logic/ex_mem_reg.sv
logic/data_mem.sv
logic/mem_stage.sv
logic/mem_wb_reg.sv
logic/mem_wb_top.sv
dv/mem_wb_props.sv
dv/tb_mem_wb.sv

// File: Bender.yml
package:
  name: mem_wb_pipe

sources:
  - include_dirs:
      - logic
    files:
      - logic/pipe_pkg.sv
      - logic/ex_mem_reg.sv
      - logic/data_mem.sv
      - logic/mem_stage.sv
      - logic/mem_wb_reg.sv
      - logic/mem_wb_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/mem_wb_props.sv
      - dv/tb_mem_wb.sv
